//--- logic/proc16_config.svh
// proc16 sizing constants for word width, memory depths and register file
`ifndef PROC16_CONFIG_SVH
`define PROC16_CONFIG_SVH

// Data and instruction word
`define WORD_WIDTH 16

// Word-addressed memories
`define IMEM_DEPTH 256
`define DMEM_DEPTH 256
`define IMEM_ADDR_W 8
`define DMEM_ADDR_W 8

// Register file
`define NUM_REGS 8
`define REG_ADDR_W 3

// Immediate field of the I-format
`define IMM_WIDTH 6

`endif

//--- logic/proc16Pkg.sv
// proc16 shared types: opcodes, instruction formats and pipeline registers
`default_nettype none
`include "proc16_config.svh"

package proc16Pkg;

    typedef enum logic [3:0] {
        opAlu  = 4'h0,
        opAddi = 4'h1,
        opLi   = 4'h2,
        opLd   = 4'h3,
        opSt   = 4'h4,
        opBeqz = 4'h5,
        opBnez = 4'h6,
        opJ    = 4'h7,
        opHalt = 4'h8,
        opNop  = 4'h9
    } opcodeT;

    typedef enum logic [2:0] {
        fnAdd = 3'd0,
        fnSub = 3'd1,
        fnAnd = 3'd2,
        fnOr  = 3'd3,
        fnXor = 3'd4,
        fnSll = 3'd5,
        fnSrl = 3'd6,
        fnSlt = 3'd7
    } funcT;

    typedef struct packed {
        opcodeT                  opcode;
        logic [`REG_ADDR_W-1:0]  rd;
        logic [`REG_ADDR_W-1:0]  rs;
        logic [`REG_ADDR_W-1:0]  rt;
        funcT                    func;
    } rFmtT;

    typedef struct packed {
        opcodeT                  opcode;
        logic [`REG_ADDR_W-1:0]  rd;
        logic [`REG_ADDR_W-1:0]  rs;
        logic [`IMM_WIDTH-1:0]   imm;   // two's complement
    } iFmtT;

    typedef union packed {
        rFmtT rFmt;
        iFmtT iFmt;
    } instrT;

    typedef struct packed {
        opcodeT opcode;
        funcT   func;
        logic   useImm;
        logic   regWrEn;
        logic   memRead;
        logic   memWrite;
        logic   branch;
        logic   branchOnZero;
        logic   jump;
        logic   halt;
        logic   illegal;
    } ctrlT;

    typedef struct packed {
        logic                    valid;
        instrT                   instr;
        logic [`IMEM_ADDR_W-1:0] pcNext;
    } fdRegT;

    typedef struct packed {
        logic                    valid;
        ctrlT                    ctrl;
        logic [`WORD_WIDTH-1:0]  opA;
        logic [`WORD_WIDTH-1:0]  opB;
        logic [`WORD_WIDTH-1:0]  storeData;
        logic [`WORD_WIDTH-1:0]  imm;
        logic [`IMEM_ADDR_W-1:0] pcNext;
        logic [`REG_ADDR_W-1:0]  writeReg;
    } deRegT;

    typedef struct packed {
        logic                   valid;
        ctrlT                   ctrl;
        logic [`WORD_WIDTH-1:0] result;
        logic [`WORD_WIDTH-1:0] storeData;
        logic [`REG_ADDR_W-1:0] writeReg;
    } emRegT;

    typedef struct packed {
        logic                   valid;
        logic                   regWrEn;
        logic                   memToReg;
        logic [`WORD_WIDTH-1:0] aluResult;
        logic [`WORD_WIDTH-1:0] readData;
        logic [`REG_ADDR_W-1:0] writeReg;
    } mwRegT;

    // Pending destination as seen by the hazard check
    typedef struct packed {
        logic                   valid;
        logic                   regWrEn;
        logic [`REG_ADDR_W-1:0] writeReg;
    } destT;

    typedef struct packed {
        logic                   valid;
        logic [`REG_ADDR_W-1:0] regNum;
        logic [`WORD_WIDTH-1:0] data;
    } wbT;

    // Writeback data select
    function automatic logic [`WORD_WIDTH-1:0] wbValue(mwRegT m);
        return m.memToReg ? m.readData : m.aluResult;
    endfunction

endpackage

`default_nettype wire

//--- logic/fetchStage.sv
// Fetch stage: program counter, instruction memory and program load port
`default_nettype none
`include "proc16_config.svh"

module fetchStage
    import proc16Pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    rstN,
    input  wire logic                    stall,
    input  wire logic                    freeze,
    input  wire logic                    redirect,
    input  wire logic [`IMEM_ADDR_W-1:0] target,
    input  wire logic                    progWrEn,
    input  wire logic [`IMEM_ADDR_W-1:0] progAddr,
    input  wire logic [`WORD_WIDTH-1:0]  progData,
    output fdRegT                        fetched
);

    logic [`WORD_WIDTH-1:0]  imem [`IMEM_DEPTH];
    logic [`IMEM_ADDR_W-1:0] pc;

    always_ff @(posedge clk) begin
        if (progWrEn) begin
            imem[progAddr] <= progData;
        end
    end

    // A halted core keeps its PC even if a branch sits behind the HALT
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else if (!freeze) begin
            if (redirect) begin
                pc <= target;
            end else if (!stall) begin
                pc <= pc + 1'b1;
            end
        end
    end

    always_comb begin
        fetched.valid  = !freeze && !progWrEn;
        fetched.instr  = imem[pc];
        fetched.pcNext = pc + 1'b1;
    end

endmodule

`default_nettype wire

//--- logic/decodeStage.sv
// Decode stage: control generation, register file and source usage flags
`default_nettype none
`include "proc16_config.svh"

module decodeStage
    import proc16Pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rstN,
    input  fdRegT                       fd,
    input  mwRegT                       wb,
    output deRegT                       de,
    output logic [`REG_ADDR_W-1:0]      rsNum,
    output logic [`REG_ADDR_W-1:0]      rtNum,
    output logic                        rsUsed,
    output logic                        rtUsed
);

    logic [`WORD_WIDTH-1:0] regs [`NUM_REGS];
    logic [`WORD_WIDTH-1:0] wbData;
    logic [`WORD_WIDTH-1:0] rsVal;
    logic [`WORD_WIDTH-1:0] rtVal;
    logic                   wbHit;
    rFmtT                   rFmt;
    iFmtT                   iFmt;
    ctrlT                   ctrl;

    assign rFmt = fd.instr.rFmt;
    assign iFmt = fd.instr.iFmt;

    always_comb begin
        ctrl        = '0;
        ctrl.opcode = iFmt.opcode;
        ctrl.func   = fnAdd;
        rsUsed      = 1'b0;
        rtUsed      = 1'b0;
        case (iFmt.opcode)
            opAlu: begin
                ctrl.func    = rFmt.func;
                ctrl.regWrEn = 1'b1;
                rsUsed       = 1'b1;
                rtUsed       = 1'b1;
            end
            opAddi: begin
                ctrl.useImm  = 1'b1;
                ctrl.regWrEn = 1'b1;
                rsUsed       = 1'b1;
            end
            opLi: begin
                ctrl.useImm  = 1'b1;
                ctrl.regWrEn = 1'b1;
            end
            opLd: begin
                ctrl.useImm  = 1'b1;
                ctrl.regWrEn = 1'b1;
                ctrl.memRead = 1'b1;
                rsUsed       = 1'b1;
            end
            opSt: begin
                ctrl.useImm   = 1'b1;
                ctrl.memWrite = 1'b1;
                rsUsed        = 1'b1;
                rtUsed        = 1'b1;
            end
            opBeqz, opBnez: begin
                ctrl.branch       = 1'b1;
                ctrl.branchOnZero = (iFmt.opcode == opBeqz);
                rsUsed            = 1'b1;
            end
            opJ:     ctrl.jump = 1'b1;
            opHalt:  ctrl.halt = 1'b1;
            opNop:   ;
            default: ctrl.illegal = 1'b1;
        endcase
    end

    // Store data from rd uses the second read port
    assign rsNum = iFmt.rs;
    assign rtNum = (iFmt.opcode == opSt) ? iFmt.rd : rFmt.rt;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int k = 0; k < `NUM_REGS; k++) begin
                regs[k] <= '0;
            end
        end else if (wbHit) begin
            regs[wb.writeReg] <= wbData;
        end
    end

    // Same-cycle write passes straight to the read ports
    assign wbHit  = wb.valid && wb.regWrEn;
    assign wbData = wbValue(wb);
    assign rsVal  = (wbHit && wb.writeReg == rsNum) ? wbData : regs[rsNum];
    assign rtVal  = (wbHit && wb.writeReg == rtNum) ? wbData : regs[rtNum];

    always_comb begin
        de.valid     = fd.valid;
        de.ctrl      = ctrl;
        de.opA       = rsVal;
        de.opB       = rtVal;
        de.storeData = rtVal;
        de.imm       = {{(`WORD_WIDTH - `IMM_WIDTH){iFmt.imm[`IMM_WIDTH-1]}}, iFmt.imm};
        de.pcNext    = fd.pcNext;
        de.writeReg  = iFmt.rd;
    end

endmodule

`default_nettype wire

//--- logic/hazardUnit.sv
// Hazard unit: dependency stall and control flush for the pipeline
`default_nettype none
`include "proc16_config.svh"

module hazardUnit
    import proc16Pkg::*;
(
    input  wire logic                   fdValid,
    input  wire logic [`REG_ADDR_W-1:0] rsNum,
    input  wire logic [`REG_ADDR_W-1:0] rtNum,
    input  wire logic                   rsUsed,
    input  wire logic                   rtUsed,
    input  destT                        deDest,
    input  destT                        emDest,
    input  wire logic                   redirect,
    input  wire logic                   haltInEm,
    output logic                        stall,
    output logic                        flush
);

    logic rsBusy;
    logic rtBusy;

    function automatic logic pending(destT d, logic [`REG_ADDR_W-1:0] n);
        return d.valid && d.regWrEn && (d.writeReg == n);
    endfunction

    // Writeback is covered by the register file bypass
    assign rsBusy = rsUsed && (pending(deDest, rsNum) || pending(emDest, rsNum));
    assign rtBusy = rtUsed && (pending(deDest, rtNum) || pending(emDest, rtNum));

    assign flush = redirect || haltInEm;
    assign stall = !flush && fdValid && (rsBusy || rtBusy);

endmodule

`default_nettype wire

//--- logic/executeStage.sv
// Execute stage: ALU, branch decision and branch target
`default_nettype none
`include "proc16_config.svh"

module executeStage
    import proc16Pkg::*;
(
    input  deRegT                        de,
    output emRegT                        em,
    output logic                         redirect,
    output logic [`IMEM_ADDR_W-1:0]      target,
    output logic                         illegal
);

    logic [`WORD_WIDTH-1:0] aluB;
    logic [`WORD_WIDTH-1:0] aluOut;
    logic                   opAZero;
    logic                   taken;

    assign aluB = de.ctrl.useImm ? de.imm : de.opB;

    // ADDI, LD and ST arrive here as an add
    always_comb begin
        case (de.ctrl.func)
            fnAdd:   aluOut = de.opA + aluB;
            fnSub:   aluOut = de.opA - aluB;
            fnAnd:   aluOut = de.opA & aluB;
            fnOr:    aluOut = de.opA | aluB;
            fnXor:   aluOut = de.opA ^ aluB;
            fnSll:   aluOut = de.opA << aluB[3:0];
            fnSrl:   aluOut = de.opA >> aluB[3:0];
            fnSlt: begin
                aluOut = '0;
                aluOut[0] = $signed(de.opA) < $signed(aluB);
            end
            default: aluOut = '0;
        endcase
    end

    assign opAZero = (de.opA == '0);
    assign taken   = (de.ctrl.branch && (opAZero == de.ctrl.branchOnZero)) || de.ctrl.jump;

    assign redirect = de.valid && taken;
    assign target   = de.pcNext + de.imm[`IMEM_ADDR_W-1:0];
    assign illegal  = de.valid && de.ctrl.illegal;

    always_comb begin
        em.valid     = de.valid;
        em.ctrl      = de.ctrl;
        em.result    = (de.ctrl.opcode == opLi) ? de.imm : aluOut;
        em.storeData = de.storeData;
        em.writeReg  = de.writeReg;
    end

endmodule

`default_nettype wire

//--- logic/memoryStage.sv
// Memory stage: data memory access with address range check
`default_nettype none
`include "proc16_config.svh"

module memoryStage
    import proc16Pkg::*;
(
    input  wire logic clk,
    input  emRegT     em,
    output mwRegT     mw,
    output logic      badAddr
);

    logic [`WORD_WIDTH-1:0]  dmem [`DMEM_DEPTH];
    logic [`DMEM_ADDR_W-1:0] addr;
    logic                    outOfRange;
    logic                    access;

    assign addr       = em.result[`DMEM_ADDR_W-1:0];
    assign outOfRange = |em.result[`WORD_WIDTH-1:`DMEM_ADDR_W];
    assign access     = em.valid && (em.ctrl.memRead || em.ctrl.memWrite);
    assign badAddr    = access && outOfRange;

    always_ff @(posedge clk) begin
        if (em.valid && em.ctrl.memWrite && !outOfRange) begin
            dmem[addr] <= em.storeData;
        end
    end

    // An out-of-range load does not write its register
    always_comb begin
        mw.valid     = em.valid;
        mw.regWrEn   = em.ctrl.regWrEn && !(em.ctrl.memRead && outOfRange);
        mw.memToReg  = em.ctrl.memRead;
        mw.aluResult = em.result;
        mw.readData  = dmem[addr];
        mw.writeReg  = em.writeReg;
    end

endmodule

`default_nettype wire

//--- logic/proc16.sv
// proc16 top: five-stage pipeline with stall, flush, halt and error state
`default_nettype none
`include "proc16_config.svh"

module proc16
    import proc16Pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    rstN,
    input  wire logic                    progWrEn,
    input  wire logic [`IMEM_ADDR_W-1:0] progAddr,
    input  wire logic [`WORD_WIDTH-1:0]  progData,
    output wbT                           wb,
    output logic                         halted,
    output logic                         err
);

    logic                    coreRstN;
    fdRegT                   fetched, fdR;
    deRegT                   deNext, deR;
    emRegT                   emNext, emR;
    mwRegT                   mwNext, mwR;
    logic [`REG_ADDR_W-1:0]  rsNum, rtNum;
    logic                    rsUsed, rtUsed;
    logic                    stall, flush, freeze;
    logic                    redirect, illegal, badAddr, haltInEm;
    logic [`IMEM_ADDR_W-1:0] target;
    destT                    deDest, emDest;

    // Loading a program keeps the core in reset
    assign coreRstN = rstN && !progWrEn;

    assign haltInEm = emR.valid && emR.ctrl.halt;
    assign freeze   = haltInEm || halted;

    fetchStage uFetch (
        .clk      (clk),
        .rstN     (coreRstN),
        .stall    (stall),
        .freeze   (freeze),
        .redirect (redirect),
        .target   (target),
        .progWrEn (progWrEn),
        .progAddr (progAddr),
        .progData (progData),
        .fetched  (fetched)
    );

    decodeStage uDecode (
        .clk    (clk),
        .rstN   (coreRstN),
        .fd     (fdR),
        .wb     (mwR),
        .de     (deNext),
        .rsNum  (rsNum),
        .rtNum  (rtNum),
        .rsUsed (rsUsed),
        .rtUsed (rtUsed)
    );

    assign deDest = '{valid: deR.valid, regWrEn: deR.ctrl.regWrEn, writeReg: deR.writeReg};
    assign emDest = '{valid: emR.valid, regWrEn: emR.ctrl.regWrEn, writeReg: emR.writeReg};

    hazardUnit uHazard (
        .fdValid  (fdR.valid),
        .rsNum    (rsNum),
        .rtNum    (rtNum),
        .rsUsed   (rsUsed),
        .rtUsed   (rtUsed),
        .deDest   (deDest),
        .emDest   (emDest),
        .redirect (redirect),
        .haltInEm (haltInEm),
        .stall    (stall),
        .flush    (flush)
    );

    executeStage uExecute (
        .de       (deR),
        .em       (emNext),
        .redirect (redirect),
        .target   (target),
        .illegal  (illegal)
    );

    memoryStage uMemory (
        .clk     (clk),
        .em      (emR),
        .mw      (mwNext),
        .badAddr (badAddr)
    );

    // Stall holds fetch/decode and inserts a bubble into decode/execute
    always_ff @(posedge clk) begin
        if (!coreRstN) begin
            fdR.valid <= 1'b0;
            deR.valid <= 1'b0;
            emR.valid <= 1'b0;
            mwR.valid <= 1'b0;
        end else begin
            if (flush || freeze) begin
                fdR.valid <= 1'b0;
            end else if (!stall) begin
                fdR <= fetched;
            end
            if (flush || freeze || stall) begin
                deR.valid <= 1'b0;
            end else begin
                deR <= deNext;
            end
            if (freeze) begin
                emR.valid <= 1'b0;
            end else begin
                emR <= emNext;
            end
            mwR <= mwNext;
        end
    end

    // Sticky status flags
    // An instruction squashed behind HALT cannot raise err
    always_ff @(posedge clk) begin
        if (!coreRstN) begin
            halted <= 1'b0;
            err    <= 1'b0;
        end else begin
            halted <= halted || haltInEm;
            err    <= err || (illegal && !freeze) || badAddr;
        end
    end

    always_comb begin
        wb.valid  = mwR.valid && mwR.regWrEn;
        wb.regNum = mwR.writeReg;
        wb.data   = wbValue(mwR);
    end

endmodule

`default_nettype wire

//--- test/tbClock.sv
// Testbench clock source with a 40-unit period
`default_nettype none

module tbClock #(
    parameter int HALF_PERIOD = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

endmodule

`default_nettype wire

//--- test/proc16Tb.sv
// proc16 testbench: program loading, instruction-set model and trace checking
`default_nettype none
`include "proc16_config.svh"

module proc16Tb
    import proc16Pkg::*;
();

    localparam int DRIVE_DLY    = 2;
    localparam int HALT_TIMEOUT = 400;
    localparam int QUIET_WINDOW = 16;

    logic                    clk;
    logic                    rstN;
    logic                    progWrEn;
    logic [`IMEM_ADDR_W-1:0] progAddr;
    logic [`WORD_WIDTH-1:0]  progData;
    wbT                      trace;
    logic                    halted;
    logic                    err;

    logic [15:0] prog [256];
    int          progLen;
    logic [15:0] modelRegs [8];
    logic [18:0] expQ [$];
    logic        expErr;
    logic [31:0] lfsr;
    int          checkErrors;
    int          casesPassed;
    int          caseNum;

    tbClock uClock (.clk(clk));

    proc16 DUT (
        .clk      (clk),
        .rstN     (rstN),
        .progWrEn (progWrEn),
        .progAddr (progAddr),
        .progData (progData),
        .wb       (trace),
        .halted   (halted),
        .err      (err)
    );

    // Galois LFSR, one step per bit
    function automatic logic nextBit();
        logic b;
        b = lfsr[0];
        lfsr = b ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        return b;
    endfunction

    function automatic int takeBits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(nextBit());
        end
        return v;
    endfunction

    function automatic logic [15:0] iWord(opcodeT op, int rd, int rs, int imm);
        return {op, rd[2:0], rs[2:0], imm[5:0]};
    endfunction

    function automatic logic [15:0] rWord(int fn, int rd, int rs, int rt);
        return {opAlu, rd[2:0], rs[2:0], rt[2:0], fn[2:0]};
    endfunction

    function automatic void put(logic [15:0] w);
        prog[progLen] = w;
        progLen++;
    endfunction

    // Straight-line ALU, ADDI and LI with narrow register fields for dependencies
    function automatic void genRandom(int n, int regBits);
        int kind;
        int rd;
        int rs;
        int rt;
        progLen = 0;
        for (int i = 0; i < n; i++) begin
            kind = takeBits(2);
            rd   = takeBits(regBits);
            rs   = takeBits(regBits);
            rt   = takeBits(regBits);
            case (kind)
                0, 1:    put(rWord(takeBits(3), rd, rs, rt));
                2:       put(iWord(opAddi, rd, rs, takeBits(6)));
                default: put(iWord(opLi, rd, 0, takeBits(6)));
            endcase
        end
        put(iWord(opHalt, 0, 0, 0));
    endfunction

    function automatic logic [15:0] aluOp(logic [2:0] fn, logic [15:0] a, logic [15:0] b);
        case (fn)
            3'd0:    return a + b;
            3'd1:    return a - b;
            3'd2:    return a & b;
            3'd3:    return a | b;
            3'd4:    return a ^ b;
            3'd5:    return a << b[3:0];
            3'd6:    return a >> b[3:0];
            default: return {15'd0, $signed(a) < $signed(b)};
        endcase
    endfunction

    function automatic void noteWrite(logic [2:0] rd, logic [15:0] v);
        modelRegs[rd] = v;
        expQ.push_back({rd, v});
    endfunction

    // Instruction-set model that runs the loaded program up to HALT
    function automatic void runReference();
        logic [15:0] mem [256];
        logic [15:0] w;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] imm;
        logic [15:0] addr;
        logic [7:0]  pc;
        logic        done;
        int          steps;
        expQ.delete();
        expErr = 1'b0;
        pc     = 8'd0;
        done   = 1'b0;
        steps  = 0;
        for (int k = 0; k < 8; k++) begin
            modelRegs[k] = 16'd0;
        end
        for (int k = 0; k < 256; k++) begin
            mem[k] = 16'd0;
        end
        while (!done && steps < 2000) begin
            w    = prog[pc];
            pc   = pc + 8'd1;
            imm  = {{10{w[5]}}, w[5:0]};
            a    = modelRegs[w[8:6]];
            b    = modelRegs[w[5:3]];
            addr = a + imm;
            case (w[15:12])
                4'h0: noteWrite(w[11:9], aluOp(w[2:0], a, b));
                4'h1: noteWrite(w[11:9], a + imm);
                4'h2: noteWrite(w[11:9], imm);
                4'h3: begin
                    if (addr > 16'd255) expErr = 1'b1;
                    else noteWrite(w[11:9], mem[addr[7:0]]);
                end
                4'h4: begin
                    if (addr > 16'd255) expErr = 1'b1;
                    else mem[addr[7:0]] = modelRegs[w[11:9]];
                end
                4'h5: if (a == 16'd0) pc = pc + imm[7:0];
                4'h6: if (a != 16'd0) pc = pc + imm[7:0];
                4'h7: pc = pc + imm[7:0];
                4'h8: done = 1'b1;
                4'h9: ;
                default: expErr = 1'b1;
            endcase
            steps++;
        end
    endfunction

    // Trace compare at the falling edge
    always @(negedge clk) begin
        logic [18:0] want;
        if (trace.valid === 1'b1) begin
            if (expQ.size() == 0) begin
                $display("Case %0d: unexpected write of %h to r%0d", caseNum, trace.data,
                         trace.regNum);
                checkErrors++;
            end else begin
                want = expQ.pop_front();
                if (trace.regNum !== want[18:16]) begin
                    $display("Error: wb.regNum expected %h got %h", want[18:16], trace.regNum);
                    checkErrors++;
                end
                if (trace.data !== want[15:0]) begin
                    $display("Error: wb.data expected %h got %h", want[15:0], trace.data);
                    checkErrors++;
                end
            end
        end
    end

    task automatic stepCycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic runCase(input string name);
        int   startErrors;
        int   cycles;
        logic lost;
        startErrors = checkErrors;
        cycles      = 0;
        lost        = 1'b0;
        caseNum++;
        runReference();
        rstN     = 1'b0;
        progWrEn = 1'b0;
        repeat (4) stepCycle();
        rstN = 1'b1;
        for (int i = 0; i < progLen; i++) begin
            progWrEn = 1'b1;
            progAddr = i[7:0];
            progData = prog[i];
            stepCycle();
        end
        progWrEn = 1'b0;
        while (!halted && cycles < HALT_TIMEOUT) begin
            stepCycle();
            cycles++;
        end
        if (!halted) begin
            $display("Case %0d: halted did not rise within %0d cycles", caseNum, HALT_TIMEOUT);
            checkErrors++;
        end
        // Nothing may retire after HALT
        for (int i = 0; i < QUIET_WINDOW; i++) begin
            stepCycle();
            if (!halted) lost = 1'b1;
        end
        if (lost) begin
            $display("Case %0d: halted fell before the next reset", caseNum);
            checkErrors++;
        end
        if (expQ.size() != 0) begin
            $display("Case %0d: %0d expected writes never appeared", caseNum, expQ.size());
            checkErrors++;
            expQ.delete();
        end
        if (err !== expErr) begin
            $display("Error: err expected %h got %h", expErr, err);
            checkErrors++;
        end
        if (checkErrors == startErrors) begin
            casesPassed++;
            $display("Case %0d %s: passed", caseNum, name);
        end else begin
            $display("Case %0d %s: failed with %0d errors", caseNum, name,
                     checkErrors - startErrors);
        end
    endtask

    initial begin
        rstN        = 1'b0;
        progWrEn    = 1'b0;
        progAddr    = '0;
        progData    = '0;
        lfsr        = 32'h96be2b8d;
        checkErrors = 0;
        casesPassed = 0;
        caseNum     = 0;

        genRandom(24, 3);
        runCase("random ALU");
        genRandom(24, 1);
        runCase("dependency chains");

        progLen = 0;
        put(iWord(opLi, 1, 0, 7));
        put(iWord(opLi, 2, 0, 3));
        put(iWord(opSt, 1, 2, 0));
        put(iWord(opSt, 2, 2, 1));
        put(iWord(opLd, 3, 2, 0));
        put(iWord(opLd, 4, 2, 1));
        put(iWord(opSt, 4, 0, 20));
        put(iWord(opAddi, 1, 1, 5));
        put(iWord(opSt, 1, 2, 0));
        put(iWord(opLd, 5, 2, 0));
        put(iWord(opLd, 6, 0, 20));
        put(iWord(opLd, 7, 2, 1));
        put(iWord(opHalt, 0, 0, 0));
        runCase("store and load");

        // Shadows hold writes that must never retire
        progLen = 0;
        put(iWord(opLi, 1, 0, 0));
        put(iWord(opBeqz, 0, 1, 2));
        put(iWord(opLi, 2, 0, 1));
        put(iWord(opLi, 3, 0, 1));
        put(iWord(opBnez, 0, 1, 1));
        put(iWord(opLi, 4, 0, 2));
        put(iWord(opLi, 5, 0, 3));
        put(iWord(opBnez, 0, 5, 1));
        put(iWord(opLi, 6, 0, 4));
        put(iWord(opBeqz, 0, 5, 1));
        put(iWord(opJ, 0, 0, 1));
        put(iWord(opLi, 7, 0, 5));
        put(iWord(opLi, 1, 0, 3));
        put(iWord(opAddi, 1, 1, -1));
        put(iWord(opBnez, 0, 1, -2));
        put(iWord(opAddi, 7, 1, 9));
        put(iWord(opHalt, 0, 0, 0));
        runCase("branches and jumps");

        progLen = 0;
        put(iWord(opLi, 1, 0, 1));
        put(iWord(opAddi, 2, 1, 2));
        put(iWord(opHalt, 0, 0, 0));
        put(iWord(opLi, 3, 0, 3));
        put(iWord(opAddi, 4, 3, 1));
        put(rWord(fnAdd, 5, 1, 2));
        put(iWord(opJ, 0, 0, -4));
        runCase("halt");

        // Alias of the bad store address keeps its value
        progLen = 0;
        put(iWord(opLi, 1, 0, 5));
        put(iWord(opLi, 2, 0, 4));
        put(rWord(fnSll, 3, 1, 2));
        put(iWord(opSt, 1, 3, 0));
        put(iWord(opLi, 4, 0, -1));
        put(iWord(opLi, 6, 0, 8));
        put(rWord(fnSll, 5, 4, 6));
        put(rWord(fnOr, 5, 5, 3));
        put(iWord(opLi, 7, 0, 9));
        put(iWord(opSt, 7, 5, 0));
        put(iWord(opLd, 0, 3, 0));
        put(iWord(opLd, 2, 5, 0));
        put(iWord(opAddi, 2, 2, 1));
        put(iWord(opHalt, 0, 0, 0));
        runCase("bad address");

        progLen = 0;
        put(iWord(opLi, 1, 0, 2));
        put(16'hA000);
        put(iWord(opAddi, 1, 1, 1));
        put(iWord(opHalt, 0, 0, 0));
        runCase("undefined opcode");

        progLen = 0;
        put(iWord(opLi, 1, 0, 0));
        put(iWord(opBeqz, 0, 1, 2));
        put(16'hB000);
        put(16'hF000);
        put(iWord(opLi, 2, 0, 3));
        put(iWord(opHalt, 0, 0, 0));
        runCase("flushed undefined opcode");

        $display("%0d of %0d cases passed, %0d failed checks", casesPassed, caseNum,
                 checkErrors);
        if (checkErrors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- proc16.f
+incdir+logic
logic/proc16Pkg.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/hazardUnit.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/proc16.sv
test/tbClock.sv
test/proc16Tb.sv

//--- build.sh
#!/bin/sh
# Builds proc16 with its testbench under Verilator and runs the simulation
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -j 0 \
    --top-module proc16Tb \
    -f proc16.f \
    -o proc16Sim

./obj_dir/proc16Sim > sim.log 2>&1
cat sim.log

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
exit 0
